//--- run.sh
#!/bin/sh
# Build with Verilator from sim.f and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f sim.f --top-module tb_pma_access_gate -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
  echo "run.sh: simulation FAILED"
  exit 1
fi
echo "run.sh: simulation finished without failures"

//--- sim.f
src/pma_pkg.sv
src/pma_checker.sv
src/access_sequencer.sv
src/bus_watchdog.sv
src/tcm_ram.sv
src/pma_access_gate.sv
tests/tb_pma_access_gate.sv

//--- src/access_sequencer.sv
// Transfer FSM steering core requests to the TCM, the external master or a fault
`timescale 1ns/100ps

module access_sequencer (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       core_cyc_i,
  input  logic                       core_stb_i,
  input  pma_pkg::core_req_t         core_req_i,
  input  pma_pkg::pma_result_t       result_i,
  output logic                       core_ack_o,
  output logic                       core_err_o,
  output logic [pma_pkg::XLEN-1:0]   core_dat_o,
  output logic                       tcm_en_o,
  output logic                       tcm_we_o,
  output logic [pma_pkg::TCM_AW-1:0] tcm_adr_o,
  output logic [3:0]                 tcm_sel_o,
  output logic [pma_pkg::XLEN-1:0]   tcm_dat_o,
  input  logic [pma_pkg::XLEN-1:0]   tcm_dat_i,
  output logic                       ext_cyc_o,
  output logic                       ext_stb_o,
  output pma_pkg::ext_req_t          ext_req_o,
  input  logic                       ext_ack_i,
  input  logic                       ext_err_i,
  input  logic [pma_pkg::XLEN-1:0]   ext_dat_i,
  output logic                       wdog_start_o,
  input  logic                       wdog_expired_i,
  output pma_pkg::fault_rec_t        fault_o
);
  import pma_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_CHECK, S_TCM, S_EXT, S_RESP, S_FAULT} state_e;

  state_e          state_q;
  logic            ext_cyc_q;
  logic            rsp_err_q;
  fault_rec_t      fault_q;
  core_req_t       req_q;
  pma_result_t     res_q;
  logic [XLEN-1:0] ext_dat_q;
  logic [3:0]      sel;

  // Byte lanes from offset and size
  always_comb begin
    case (req_q.size)
      BYTE:    sel = 4'b0001 << req_q.adr[1:0];
      HWORD:   sel = 4'b0011 << req_q.adr[1:0];
      default: sel = 4'b1111;
    endcase
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= S_IDLE;
      ext_cyc_q <= 1'b0;
      rsp_err_q <= 1'b0;
      fault_q   <= '{cause: FAULT_NONE, adr: '0, valid: 1'b0};
    end else begin
      case (state_q)
        S_IDLE: begin
          if (core_cyc_i && core_stb_i) begin
            state_q <= S_CHECK;
          end
        end
        // Live request still held by the core
        S_CHECK: begin
          if (result_i.to_tcm) begin
            state_q <= S_TCM;
          end else if (result_i.to_ext) begin
            state_q <= S_EXT;
          end else begin
            state_q <= S_FAULT;
          end
        end
        S_TCM: begin
          rsp_err_q <= 1'b0;
          state_q   <= S_RESP;
        end
        S_FAULT: begin
          rsp_err_q <= 1'b1;
          fault_q   <= '{cause: res_q.misaligned_fault ? FAULT_MISALIGNED : FAULT_ACCESS,
                         adr: req_q.adr, valid: 1'b1};
          state_q   <= S_RESP;
        end
        S_EXT: begin
          // First cycle only arms the watchdog
          if (!ext_cyc_q) begin
            ext_cyc_q <= 1'b1;
          end else if (ext_ack_i || ext_err_i || wdog_expired_i) begin
            ext_cyc_q <= 1'b0;
            state_q   <= S_RESP;
            rsp_err_q <= !ext_ack_i;
            if (!ext_ack_i) begin
              fault_q <= '{cause: ext_err_i ? FAULT_ACCESS : FAULT_TIMEOUT,
                           adr: req_q.adr, valid: 1'b1};
            end
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Payload, no reset
  always_ff @(posedge clk_i) begin
    if (state_q == S_CHECK) begin
      req_q <= core_req_i;
      res_q <= result_i;
    end
    if (state_q == S_EXT && ext_cyc_q && ext_ack_i) begin
      ext_dat_q <= ext_dat_i;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign core_ack_o = (state_q == S_RESP) && !rsp_err_q;
  assign core_err_o = (state_q == S_RESP) && rsp_err_q;
  // TCM read data stays on the RAM register until the next enable
  assign core_dat_o = res_q.to_tcm ? tcm_dat_i : ext_dat_q;

  assign tcm_en_o   = (state_q == S_TCM);
  assign tcm_we_o   = req_q.we;
  assign tcm_adr_o  = req_q.adr[TCM_AW+1:2];
  assign tcm_sel_o  = sel;
  assign tcm_dat_o  = req_q.dat;

  assign ext_cyc_o  = ext_cyc_q;
  assign ext_stb_o  = ext_cyc_q;
  assign ext_req_o  = '{adr: req_q.adr, dat: req_q.dat, sel: sel, we: req_q.we,
                        tga_cacheable: res_q.cacheable};

  assign wdog_start_o = (state_q == S_EXT) && !ext_cyc_q;
  assign fault_o      = fault_q;

endmodule

//--- src/bus_watchdog.sv
// Down counter that flags an external transfer waiting too long for an acknowledge
`timescale 1ns/100ps

module bus_watchdog (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  input  logic busy_i,
  output logic expired_o
);
  import pma_pkg::*;

  logic [WDOG_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q     <= '0;
      expired_o <= 1'b0;
    end else begin
      expired_o <= 1'b0;
      if (start_i) begin
        cnt_q <= WDOG_CNT_W'(WDOG_LIMIT);
      end else if (!busy_i) begin
        // Transfer done, never fires late
        cnt_q <= '0;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
        // Pulse on the step to zero
        expired_o <= (cnt_q == WDOG_CNT_W'(1));
      end
    end
  end

endmodule

//--- src/pma_access_gate.sv
// Top level of the PMA gate with checker, sequencer, watchdog and TCM
`timescale 1ns/100ps

module pma_access_gate (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic                                                   core_cyc_i,
  input  logic                                                   core_stb_i,
  input  pma_pkg::core_req_t                                     core_req_i,
  output logic                                                   core_ack_o,
  output logic                                                   core_err_o,
  output logic [pma_pkg::XLEN-1:0]                               core_dat_o,
  output logic                                                   ext_cyc_o,
  output logic                                                   ext_stb_o,
  output pma_pkg::ext_req_t                                      ext_req_o,
  input  logic                                                   ext_ack_i,
  input  logic                                                   ext_err_i,
  input  logic [pma_pkg::XLEN-1:0]                               ext_dat_i,
  input  pma_pkg::pma_cfg_t [pma_pkg::PMA_CNT-1:0]               pma_cfg_i,
  input  logic [pma_pkg::PMA_CNT-1:0][pma_pkg::XLEN-1:0]         pma_adr_i,
  output pma_pkg::fault_rec_t                                    fault_o
);
  import pma_pkg::*;

  pma_result_t       result;
  logic              tcm_en;
  logic              tcm_we;
  logic [TCM_AW-1:0] tcm_adr;
  logic [3:0]        tcm_sel;
  logic [XLEN-1:0]   tcm_wdat;
  logic [XLEN-1:0]   tcm_rdat;
  logic              wdog_start;
  logic              wdog_expired;

  // Checks the live request, sampled by the FSM in CHECK
  pma_checker i_pma_checker (
    .pma_cfg_i (pma_cfg_i),
    .pma_adr_i (pma_adr_i),
    .req_i     (core_req_i),
    .result_o  (result)
  );

  access_sequencer i_access_sequencer (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .core_cyc_i     (core_cyc_i),
    .core_stb_i     (core_stb_i),
    .core_req_i     (core_req_i),
    .result_i       (result),
    .core_ack_o     (core_ack_o),
    .core_err_o     (core_err_o),
    .core_dat_o     (core_dat_o),
    .tcm_en_o       (tcm_en),
    .tcm_we_o       (tcm_we),
    .tcm_adr_o      (tcm_adr),
    .tcm_sel_o      (tcm_sel),
    .tcm_dat_o      (tcm_wdat),
    .tcm_dat_i      (tcm_rdat),
    .ext_cyc_o      (ext_cyc_o),
    .ext_stb_o      (ext_stb_o),
    .ext_req_o      (ext_req_o),
    .ext_ack_i      (ext_ack_i),
    .ext_err_i      (ext_err_i),
    .ext_dat_i      (ext_dat_i),
    .wdog_start_o   (wdog_start),
    .wdog_expired_i (wdog_expired),
    .fault_o        (fault_o)
  );

  // Busy for as long as the external cycle is open
  bus_watchdog i_bus_watchdog (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (wdog_start),
    .busy_i    (ext_cyc_o),
    .expired_o (wdog_expired)
  );

  tcm_ram i_tcm_ram (
    .clk_i (clk_i),
    .en_i  (tcm_en),
    .we_i  (tcm_we),
    .adr_i (tcm_adr),
    .sel_i (tcm_sel),
    .dat_i (tcm_wdat),
    .dat_o (tcm_rdat)
  );

endmodule

//--- src/pma_checker.sv
// Combinational PMA region matcher with permission, alignment and route classifier
`timescale 1ns/100ps

module pma_checker (
  input  pma_pkg::pma_cfg_t   [pma_pkg::PMA_CNT-1:0]                    pma_cfg_i,
  input  logic                [pma_pkg::PMA_CNT-1:0][pma_pkg::XLEN-1:0] pma_adr_i,
  input  pma_pkg::core_req_t                                             req_i,
  output pma_pkg::pma_result_t                                           result_o
);
  import pma_pkg::*;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Bytes covered by one transfer
  function automatic logic [3:0] size_bytes(input xfer_size_e size);
    case (size)
      BYTE:    size_bytes = 4'd1;
      HWORD:   size_bytes = 4'd2;
      WORD:    size_bytes = 4'd4;
      default: size_bytes = 4'd8;
    endcase
  endfunction

  // Word mask of a NA4/NAPOT region
  // NAPOT size is 2^(trailing ones + 1) words
  function automatic logic [PLEN-2:0] napot_mask(input logic na4, input logic [PLEN-3:0] pmaddr);
    logic [PLEN-2:0] mask;
    logic            ones;
    int              b;
    mask = '1;
    ones = 1'b1;
    if (!na4) begin
      mask = mask << 1;
      for (b = 0; b < PLEN - 2; b++) begin
        if (ones && pmaddr[b]) begin
          mask = mask << 1;
        end else begin
          ones = 1'b0;
        end
      end
    end
    napot_mask = mask;
  endfunction

  //////////////////////////////
  // Signals
  //////////////////////////////

  pma_cfg_t        cfg_s  [PMA_CNT];
  // Bounds in words with one extra carry bit
  // Upper bound is exclusive
  logic [PLEN-2:0] pma_lb [PMA_CNT];
  logic [PLEN-2:0] pma_ub [PMA_CNT];
  logic [PLEN-2:0] nap_lb [PMA_CNT];
  logic [PLEN-2:0] nap_ub [PMA_CNT];
  logic [PMA_CNT-1:0] hit;
  pma_cfg_t        sel_cfg;
  logic [3:0]      nbytes;
  logic [PLEN-1:0] acc_last;
  logic [PLEN-2:0] acc_lb_w;
  logic [PLEN-2:0] acc_ub_w;
  logic            unaligned;
  logic            crosses;
  logic            acc_fault;
  logic            mis_fault;
  logic            ok;

  // Descriptor cleanup
  always_comb begin
    for (int i = 0; i < PMA_CNT; i++) begin
      cfg_s[i] = pma_cfg_i[i];
      // Empty slot acts as IO without any permission
      if (pma_cfg_i[i].mem_type == MEM_EMPTY) begin
        cfg_s[i].mem_type   = MEM_IO;
        cfg_s[i].readable   = 1'b0;
        cfg_s[i].writable   = 1'b0;
        cfg_s[i].executable = 1'b0;
        cfg_s[i].amo_type   = 2'b00;
      end
      // Only main memory may be cached
      cfg_s[i].cacheable = (pma_cfg_i[i].mem_type == MEM_MAIN) && pma_cfg_i[i].cacheable;
      cfg_s[i].coherent  = pma_cfg_i[i].coherent && cfg_s[i].cacheable;
      if (pma_cfg_i[i].mem_type != MEM_IO) begin
        cfg_s[i].idem_rd = 1'b1;
        cfg_s[i].idem_wr = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Region bounds
  //////////////////////////////

  always_comb begin
    int prev;
    for (int i = 0; i < PMA_CNT; i++) begin
      nap_lb[i] = {1'b0, pma_adr_i[i][PLEN-3:0]} &
                  napot_mask(cfg_s[i].mode == PMA_NA4, pma_adr_i[i][PLEN-3:0]);
      nap_ub[i] = nap_lb[i] +
                  (~napot_mask(cfg_s[i].mode == PMA_NA4, pma_adr_i[i][PLEN-3:0]) + 1'b1);
    end
    for (int i = 0; i < PMA_CNT; i++) begin
      prev = (i == 0) ? 0 : i - 1;
      case (cfg_s[i].mode)
        PMA_TOR: begin
          // TOR after NA4/NAPOT starts where that region ends
          if (i == 0) begin
            pma_lb[i] = '0;
          end else if (cfg_s[prev].mode inside {PMA_NA4, PMA_NAPOT}) begin
            pma_lb[i] = nap_ub[prev];
          end else begin
            pma_lb[i] = {1'b0, pma_adr_i[prev][PLEN-3:0]};
          end
          pma_ub[i] = {1'b0, pma_adr_i[i][PLEN-3:0]};
        end
        PMA_NA4, PMA_NAPOT: begin
          pma_lb[i] = nap_lb[i];
          pma_ub[i] = nap_ub[i];
        end
        default: begin
          pma_lb[i] = '0;
          pma_ub[i] = '0;
        end
      endcase
    end
  end

  //////////////////////////////
  // Access range and match
  //////////////////////////////

  assign nbytes   = size_bytes(req_i.size);
  assign acc_last = req_i.adr + PLEN'(nbytes) - PLEN'(1);
  assign acc_lb_w = {1'b0, req_i.adr[PLEN-1:2]};
  assign acc_ub_w = {1'b0, acc_last[PLEN-1:2]};

  // Every byte of the access inside the region
  always_comb begin
    for (int i = 0; i < PMA_CNT; i++) begin
      hit[i] = (cfg_s[i].mode != PMA_OFF) && (acc_lb_w >= pma_lb[i]) && (acc_ub_w < pma_ub[i]);
    end
  end

  // Lowest index wins
  always_comb begin
    sel_cfg = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_cfg = cfg_s[i];
      end
    end
  end

  // Offset bits below the size must be zero
  assign unaligned = (req_i.adr[1:0] & (nbytes[1:0] - 2'd1)) != 2'b00;
  assign crosses   = ({3'b000, req_i.adr[1:0]} + {1'b0, nbytes}) > 5'd4;

  // Fetch needs execute, store needs write, load needs read
  assign acc_fault = ~|hit
                   | (req_i.instr & ~sel_cfg.executable)
                   | (req_i.we & ~sel_cfg.writable)
                   | (~req_i.instr & ~req_i.we & ~sel_cfg.readable);
  assign mis_fault = crosses | (|hit & unaligned & ~sel_cfg.misaligned);
  assign ok        = ~acc_fault & ~mis_fault;

  assign result_o.access_fault     = acc_fault;
  assign result_o.misaligned_fault = mis_fault;
  assign result_o.to_tcm           = ok & (sel_cfg.mem_type == MEM_TCM);
  assign result_o.to_ext           = ok & (sel_cfg.mem_type != MEM_TCM);
  assign result_o.cacheable        = ok & sel_cfg.cacheable;

endmodule

//--- src/pma_pkg.sv
// Shared sizes, attribute codes and transfer structs for the PMA access gate
package pma_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int XLEN       = 32;
  localparam int PLEN       = 32;
  localparam int PMA_CNT    = 4;
  localparam int TCM_WORDS  = 1024;
  localparam int TCM_AW     = $clog2(TCM_WORDS);
  localparam int WDOG_LIMIT = 16;
  localparam int WDOG_CNT_W = $clog2(WDOG_LIMIT + 1);

  //////////////////////////////
  // Codes
  //////////////////////////////

  typedef enum logic [1:0] {MEM_EMPTY, MEM_MAIN, MEM_IO, MEM_TCM} mem_type_e;

  typedef enum logic [1:0] {PMA_OFF, PMA_TOR, PMA_NA4, PMA_NAPOT} pma_mode_e;

  // Transfer size, matches the core's encoding
  typedef enum logic [2:0] {BYTE = 3'd0, HWORD = 3'd1, WORD = 3'd2} xfer_size_e;

  typedef enum logic [1:0] {
    FAULT_NONE,
    FAULT_ACCESS,
    FAULT_MISALIGNED,
    FAULT_TIMEOUT
  } fault_cause_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Region descriptor, 14 bits
  typedef struct packed {
    mem_type_e   mem_type;
    logic        readable;
    logic        writable;
    logic        executable;
    logic        cacheable;
    logic        coherent;
    logic        idem_rd;
    logic        idem_wr;
    logic        misaligned;
    logic [1:0]  amo_type;
    pma_mode_e   mode;
  } pma_cfg_t;

  // Core transfer, 71 bits
  typedef struct packed {
    logic [PLEN-1:0] adr;
    logic [XLEN-1:0] dat;
    xfer_size_e      size;
    logic            we;
    logic            instr;
    // Reserved for lock and AMO hints
    logic [1:0]      rsvd;
  } core_req_t;

  // External master request, 70 bits
  typedef struct packed {
    logic [PLEN-1:0] adr;
    logic [XLEN-1:0] dat;
    logic [3:0]      sel;
    logic            we;
    logic            tga_cacheable;
  } ext_req_t;

  typedef struct packed {
    logic access_fault;
    logic misaligned_fault;
    logic to_tcm;
    logic to_ext;
    logic cacheable;
  } pma_result_t;

  // Most recent fault
  typedef struct packed {
    fault_cause_e    cause;
    logic [PLEN-1:0] adr;
    logic            valid;
  } fault_rec_t;

endpackage

//--- src/tcm_ram.sv
// Word-wide tightly coupled memory with byte-lane writes and registered read
`timescale 1ns/100ps

module tcm_ram (
  input  logic                       clk_i,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [pma_pkg::TCM_AW-1:0] adr_i,
  input  logic [3:0]                 sel_i,
  input  logic [pma_pkg::XLEN-1:0]   dat_i,
  output logic [pma_pkg::XLEN-1:0]   dat_o
);
  import pma_pkg::*;

  logic [XLEN-1:0] mem_q [TCM_WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      // Read first, old word on a write
      dat_o <= mem_q[adr_i];
      if (we_i) begin
        for (int b = 0; b < XLEN / 8; b++) begin
          if (sel_i[b]) begin
            mem_q[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

//--- tests/tb_pma_access_gate.sv
// Directed testbench for the PMA access gate with external slave model and test tasks
`timescale 1ns/100ps

module tb_pma_access_gate;
  import pma_pkg::*;

  localparam int CLK_HALF     = 2;
  localparam int RESET_CYCLES = 8;
  // About 60 transfers of at most 25 cycles plus reset and slack
  localparam int CYCLE_LIMIT  = 60 * 25 + 500;
  // Longest single transfer is a watchdog abort
  localparam int XFER_LIMIT   = 2 * WDOG_LIMIT + 8;
  localparam int SLAVE_WORDS  = 64;

  logic                              clk;
  logic                              reset;
  logic                              core_cyc;
  logic                              core_stb;
  core_req_t                         core_req;
  logic                              core_ack;
  logic                              core_err;
  logic [XLEN-1:0]                   core_dat;
  logic                              ext_cyc;
  logic                              ext_stb;
  ext_req_t                          ext_req;
  logic                              ext_ack = 1'b0;
  logic                              ext_err = 1'b0;
  logic [XLEN-1:0]                   ext_dat = '0;
  pma_cfg_t [PMA_CNT-1:0]            pma_cfg;
  logic [PMA_CNT-1:0][XLEN-1:0]      pma_adr;
  fault_rec_t                        fault;

  // Slave model controls and memory
  logic            slave_silent   = 1'b0;
  logic            slave_err_mode = 1'b0;
  logic [XLEN-1:0] slave_mem [SLAVE_WORDS];
  int              slave_wait;
  int              cycle_count = 0;

  // Results of the last transfer
  int              last_lat;
  logic            last_err;
  logic [XLEN-1:0] last_dat;
  logic            ext_used;
  ext_req_t        ext_seen;
  logic            resp_after_ext;
  logic            cyc_at_resp;

  pma_access_gate i_pma_access_gate (
    .clk_i      (clk),
    .reset_i    (reset),
    .core_cyc_i (core_cyc),
    .core_stb_i (core_stb),
    .core_req_i (core_req),
    .core_ack_o (core_ack),
    .core_err_o (core_err),
    .core_dat_o (core_dat),
    .ext_cyc_o  (ext_cyc),
    .ext_stb_o  (ext_stb),
    .ext_req_o  (ext_req),
    .ext_ack_i  (ext_ack),
    .ext_err_i  (ext_err),
    .ext_dat_i  (ext_dat),
    .pma_cfg_i  (pma_cfg),
    .pma_adr_i  (pma_adr),
    .fault_o    (fault)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  //////////////////////////////
  // External slave model
  //////////////////////////////

  // Reset pattern unique per word index
  function automatic logic [XLEN-1:0] fill_word(input int idx);
    fill_word = {8'hC3, 8'(idx), 8'(~idx), 8'(idx ^ 8'h5A)};
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      ext_ack    <= 1'b0;
      ext_err    <= 1'b0;
      slave_wait = -1;
      for (int i = 0; i < SLAVE_WORDS; i++) begin
        slave_mem[i] <= fill_word(i);
      end
    end else begin
      ext_ack <= 1'b0;
      ext_err <= 1'b0;
      if (!(ext_cyc && ext_stb) || ext_ack || ext_err || slave_silent) begin
        slave_wait = -1;
      end else begin
        // Random wait for a new request
        if (slave_wait < 0) begin
          slave_wait = $urandom_range(3, 0);
        end
        if (slave_wait == 0) begin
          slave_wait = -1;
          if (slave_err_mode) begin
            ext_err <= 1'b1;
          end else begin
            ext_ack <= 1'b1;
            if (ext_req.we) begin
              for (int b = 0; b < 4; b++) begin
                if (ext_req.sel[b]) begin
                  slave_mem[ext_req.adr[7:2]][8*b +: 8] <= ext_req.dat[8*b +: 8];
                end
              end
            end else begin
              ext_dat <= slave_mem[ext_req.adr[7:2]];
            end
          end
        end else begin
          slave_wait = slave_wait - 1;
        end
      end
    end
  end

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  // Run limit over the whole simulation
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_failure();
    end
  end

  function automatic pma_cfg_t make_cfg(input mem_type_e mt, input logic [2:0] rwx,
                                        input logic cacheable, input logic misaligned,
                                        input pma_mode_e mode);
    pma_cfg_t cfg;
    cfg            = '0;
    cfg.mem_type   = mt;
    cfg.readable   = rwx[2];
    cfg.writable   = rwx[1];
    cfg.executable = rwx[0];
    cfg.cacheable  = cacheable;
    cfg.misaligned = misaligned;
    cfg.mode       = mode;
    make_cfg = cfg;
  endfunction

  //////////////////////////////
  // Transfer tasks
  //////////////////////////////

  // One Wishbone classic transfer with outputs sampled on the falling edge
  task automatic run_transfer(input logic [31:0] adr, input logic [31:0] dat,
                              input xfer_size_e size, input logic we, input logic instr);
    core_req_t req;
    int        waited;
    logic      ext_resp_prev;
    req           = '0;
    req.adr       = adr;
    req.dat       = dat;
    req.size      = size;
    req.we        = we;
    req.instr     = instr;
    ext_used      = 1'b0;
    ext_resp_prev = 1'b0;
    @(posedge clk);
    core_cyc <= 1'b1;
    core_stb <= 1'b1;
    core_req <= req;
    // Edge 0 where the DUT first sees the request
    @(posedge clk);
    waited = 0;
    @(negedge clk);
    while (!(core_ack || core_err)) begin
      if (ext_cyc && ext_stb) begin
        ext_used = 1'b1;
        ext_seen = ext_req;
      end
      ext_resp_prev = ext_ack || ext_err;
      @(negedge clk);
      waited++;
      if (waited > XFER_LIMIT) begin
        $display("Timeout: no ack or err from the DUT at address %0h", adr);
        stop_on_failure();
      end
    end
    last_lat       = waited;
    last_err       = core_err;
    last_dat       = core_dat;
    resp_after_ext = ext_resp_prev;
    cyc_at_resp    = ext_cyc;
    @(posedge clk);
    core_cyc <= 1'b0;
    core_stb <= 1'b0;
    @(negedge clk);
    check_eq("response lasts one cycle", core_ack | core_err, 1'b0);
  endtask

  task automatic core_write(input logic [31:0] adr, input logic [31:0] dat,
                            input xfer_size_e size);
    run_transfer(adr, dat, size, 1'b1, 1'b0);
  endtask

  task automatic core_read(input logic [31:0] adr, input xfer_size_e size);
    run_transfer(adr, '0, size, 1'b0, 1'b0);
  endtask

  // TCM hit with fixed latency and no external traffic
  task automatic check_tcm_done(input string what);
    check_eq({what, " err"}, last_err, 1'b0);
    check_eq({what, " latency"}, last_lat, 2);
    check_eq({what, " external port idle"}, ext_used, 1'b0);
  endtask

  task automatic check_ext_done(input string what, input logic [31:0] adr,
                                input logic [3:0] sel, input logic we, input logic tga);
    check_eq({what, " err"}, last_err, 1'b0);
    check_eq({what, " external used"}, ext_used, 1'b1);
    check_eq({what, " external adr"}, ext_seen.adr, adr);
    check_eq({what, " external sel"}, ext_seen.sel, sel);
    check_eq({what, " external we"}, ext_seen.we, we);
    check_eq({what, " cacheable tag"}, ext_seen.tga_cacheable, tga);
    check_eq({what, " ack one cycle after slave"}, resp_after_ext, 1'b1);
  endtask

  task automatic check_fault(input string what, input fault_cause_e cause,
                             input logic [31:0] adr);
    check_eq({what, " err"}, last_err, 1'b1);
    check_eq({what, " latency"}, last_lat, 2);
    check_eq({what, " external port idle"}, ext_used, 1'b0);
    check_eq({what, " fault valid"}, fault.valid, 1'b1);
    check_eq({what, " fault cause"}, fault.cause, cause);
    check_eq({what, " fault adr"}, fault.adr, adr);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check_eq("ack after reset", core_ack, 1'b0);
    check_eq("err after reset", core_err, 1'b0);
    check_eq("ext cyc after reset", ext_cyc, 1'b0);
    check_eq("ext stb after reset", ext_stb, 1'b0);
    check_eq("fault valid after reset", fault.valid, 1'b0);
  endtask

  task automatic test_tcm_access();
    core_write(32'h0000_0100, 32'h1122_3344, WORD);
    check_tcm_done("tcm word write");
    core_write(32'h0000_0101, 32'h0000_AA00, BYTE);
    check_tcm_done("tcm byte write");
    core_write(32'h0000_0102, 32'hBEEF_0000, HWORD);
    check_tcm_done("tcm halfword write");
    core_read(32'h0000_0100, WORD);
    check_tcm_done("tcm merged read");
    check_eq("tcm merged data", last_dat, 32'hBEEF_AA44);
    // Last word of the TCM
    core_write(32'h0000_0FFC, 32'hCAFE_F00D, WORD);
    check_tcm_done("tcm top write");
    core_read(32'h0000_0FFC, WORD);
    check_tcm_done("tcm top read");
    check_eq("tcm top data", last_dat, 32'hCAFE_F00D);
    check_eq("no fault after tcm traffic", fault.valid, 1'b0);
  endtask

  task automatic test_ext_routing();
    logic [31:0] adr;
    logic [31:0] dat;
    // IO region is never cacheable
    core_read(32'h8000_0010, WORD);
    check_ext_done("io read", 32'h8000_0010, 4'b1111, 1'b0, 1'b0);
    check_eq("io read data", last_dat, slave_mem[4]);
    for (int n = 0; n < 6; n++) begin
      adr = 32'h0000_1000 + (32'($urandom_range(SLAVE_WORDS - 1, 0)) << 2);
      dat = $urandom;
      core_write(adr, dat, WORD);
      check_ext_done("main write", adr, 4'b1111, 1'b1, 1'b1);
      check_eq("main write data", ext_seen.dat, dat);
      core_read(adr, WORD);
      check_ext_done("main read", adr, 4'b1111, 1'b0, 1'b1);
      check_eq("main read data", last_dat, dat);
    end
    core_write(32'h0000_1040, 32'h0123_4567, WORD);
    check_ext_done("main word write", 32'h0000_1040, 4'b1111, 1'b1, 1'b1);
    core_write(32'h0000_1042, 32'h005A_0000, BYTE);
    check_ext_done("main byte write", 32'h0000_1042, 4'b0100, 1'b1, 1'b1);
    core_write(32'h0000_1040, 32'h0000_BEEF, HWORD);
    check_ext_done("main halfword write", 32'h0000_1040, 4'b0011, 1'b1, 1'b1);
    core_read(32'h0000_1040, WORD);
    check_ext_done("main merged read", 32'h0000_1040, 4'b1111, 1'b0, 1'b1);
    check_eq("main merged data", last_dat, 32'h015A_BEEF);
  endtask

  task automatic test_access_faults();
    core_write(32'h8000_0004, 32'h1234_5678, WORD);
    check_fault("write to read-only io", FAULT_ACCESS, 32'h8000_0004);
    run_transfer(32'h0000_1000, '0, WORD, 1'b0, 1'b1);
    check_fault("fetch from main", FAULT_ACCESS, 32'h0000_1000);
    core_read(32'h4000_0000, WORD);
    check_fault("unmapped read", FAULT_ACCESS, 32'h4000_0000);
    // Fetch from the TCM is allowed
    run_transfer(32'h0000_0100, '0, WORD, 1'b0, 1'b1);
    check_tcm_done("tcm fetch");
    check_eq("tcm fetch data", last_dat, 32'hBEEF_AA44);
  endtask

  task automatic test_misaligned();
    core_write(32'h0000_0200, 32'h1111_1111, WORD);
    check_tcm_done("tcm base write");
    core_write(32'h0000_0201, 32'h00AB_CD00, HWORD);
    check_tcm_done("tcm odd halfword write");
    core_read(32'h0000_0201, HWORD);
    check_tcm_done("tcm odd halfword read");
    check_eq("tcm odd halfword data", last_dat, 32'h11AB_CD11);
    core_write(32'h0000_1001, 32'h00AB_CD00, HWORD);
    check_fault("main odd halfword", FAULT_MISALIGNED, 32'h0000_1001);
    core_read(32'h0000_0202, WORD);
    check_fault("tcm word crossing", FAULT_MISALIGNED, 32'h0000_0202);
    core_read(32'h0000_1003, HWORD);
    check_fault("main halfword crossing", FAULT_MISALIGNED, 32'h0000_1003);
  endtask

  task automatic test_watchdog();
    slave_silent = 1'b1;
    core_read(32'h0000_1010, WORD);
    check_eq("timeout err", last_err, 1'b1);
    // Strobe rises at edge 2 and the err follows the expiry by one cycle
    check_eq("timeout latency", last_lat, WDOG_LIMIT + 3);
    check_eq("timeout external used", ext_used, 1'b1);
    check_eq("timeout cyc dropped", cyc_at_resp, 1'b0);
    check_eq("timeout cause", fault.cause, FAULT_TIMEOUT);
    check_eq("timeout fault adr", fault.adr, 32'h0000_1010);
    slave_silent = 1'b0;
    core_read(32'h0000_1010, WORD);
    check_ext_done("read after timeout", 32'h0000_1010, 4'b1111, 1'b0, 1'b1);
    check_eq("read after timeout data", last_dat, slave_mem[4]);
  endtask

  task automatic test_slave_error();
    slave_err_mode = 1'b1;
    core_write(32'h0000_1020, 32'hDEAD_BEEF, WORD);
    slave_err_mode = 1'b0;
    check_eq("slave error err", last_err, 1'b1);
    check_eq("slave error external used", ext_used, 1'b1);
    check_eq("slave error cyc dropped", cyc_at_resp, 1'b0);
    check_eq("slave error cause", fault.cause, FAULT_ACCESS);
    check_eq("slave error fault adr", fault.adr, 32'h0000_1020);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h477881e6));
    reset    <= 1'b1;
    core_cyc <= 1'b0;
    core_stb <= 1'b0;
    core_req <= '0;
    // Region 0 is a 4 KB TCM at address 0
    // Region 1 is main memory from 0x1000 to 0x2000
    // Region 2 is 64 B of IO at 0x8000_0000
    pma_cfg[0] <= make_cfg(MEM_TCM, 3'b111, 1'b0, 1'b1, PMA_NAPOT);
    pma_cfg[1] <= make_cfg(MEM_MAIN, 3'b110, 1'b1, 1'b0, PMA_TOR);
    pma_cfg[2] <= make_cfg(MEM_IO, 3'b100, 1'b0, 1'b0, PMA_NAPOT);
    pma_cfg[3] <= make_cfg(MEM_EMPTY, 3'b000, 1'b0, 1'b0, PMA_OFF);
    pma_adr[0] <= 32'h0000_01FF;
    pma_adr[1] <= 32'h0000_0800;
    pma_adr[2] <= 32'h2000_0007;
    pma_adr[3] <= 32'h0000_0000;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_tcm_access();
    test_ext_routing();
    test_access_faults();
    test_misaligned();
    test_watchdog();
    test_slave_error();
    $display("Simulation passed");
    $finish;
  end

endmodule
